// File: isaPkg.sv
package isaPkg;

	localparam int BIOS_WORDS = 37; // boot image size in words

	localparam logic [1:0] RESP_OKAY = 2'b00; // axi write accepted
	localparam logic [1:0] RESP_SLVERR = 2'b10; // outside program window

	// opcode map of the teaching cpu
	typedef enum logic [5:0] {
		opAdd = 6'b000000, opAddi = 6'b000001, opSub = 6'b000010, opSubi = 6'b000011,
		opMult = 6'b000100, opMulti = 6'b000101, opDiv = 6'b000110, opDivi = 6'b000111,
		opRdiv = 6'b001000, // remainder
		opJ = 6'b010001, opJumpR = 6'b010010, opJal = 6'b010011, // jumps
		opBeq = 6'b010100, opBne = 6'b010101, opBlt = 6'b010110, // branches
		opLw = 6'b010111, opSw = 6'b011000, // data memory
		opMov = 6'b011001, opMovi = 6'b011010, opMfhi = 6'b011011, opMflo = 6'b011100,
		opIn = 6'b011101, opOut = 6'b011110, // console io
		opScpc = 6'b100001, opScrg = 6'b100010, // context save
		opCproc = 6'b100011, opEncBios = 6'b100100, opLed = 6'b100101, opSpc = 6'b100110,
		opEnd = 6'b111111 // program finished
	} opcodeT;

	typedef struct packed {
		opcodeT opcode; // 31:26
		logic [4:0] rd; // 25:21
		logic [4:0] rs; // 20:16
		logic [4:0] rt; // 15:11
		logic [10:0] imm; // 10:0
	} rFormatT;

	typedef struct packed {
		opcodeT opcode; // 31:26
		logic [25:0] target; // jump target word index
	} jFormatT;

	// same word, register view or jump view
	typedef union packed {
		rFormatT r;
		jFormatT j;
	} instrWordT;

	typedef struct packed {
		logic awvalid;
		logic [31:0] awaddr; // byte address
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb; // one bit per byte lane
		logic bready;
	} axiWrReqT;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
	} axiWrRspT;

	// bios: clear r0..r29, r30=1, r31=11, then loop over the process status table
	function automatic instrWordT biosWord(input logic [31:0] idx);
		instrWordT w;
		w = '0; // unused fields stay zero
		if (idx == 32'd0) begin
			w.j = '{opCproc, 26'd0}; // run as os process
		end else if (idx <= 32'd30) begin
			w.r.opcode = opMovi; // movi r(n-1), 0
			w.r.rd = 5'(idx - 32'd1);
		end else begin
			case (idx)
				32'd31: w.r = '{opMovi, 5'd30, 5'd0, 5'd0, 11'd1}; // r30 = 1
				32'd32: w.r = '{opMovi, 5'd31, 5'd30, 5'd30, 11'd11}; // loop bound
				32'd33: w.r = '{opSw, 5'd0, 5'd30, 5'd0, 11'd1}; // clear status slot
				32'd34: w.r = '{opAddi, 5'd30, 5'd30, 5'd30, 11'd1}; // next slot
				32'd35: w.r = '{opBeq, 5'd0, 5'd30, 5'd31, 11'd2}; // leave when done
				32'd36: w.j = '{opJ, 26'd33}; // back to sw
				default: w = '0; // beyond the image
			endcase
		end
		return w;
	endfunction

endpackage

// File: bootRom.sv
`timescale 1ns/100ps

module bootRom (
	input logic clock,
	input logic [31:0] pc, // word index
	output isaPkg::instrWordT romWord
);

	logic inBios; // pc inside boot image
	isaPkg::instrWordT romNext; // word for the current pc
	isaPkg::instrWordT romAtNeg; // mid-cycle copy for the edge check

	assign inBios = pc < 32'(isaPkg::BIOS_WORDS);

	always_comb begin
		if (inBios) begin
			romNext = isaPkg::biosWord(pc); // constant table, folds to logic
		end else begin
			romNext = '0; // outside rom reads as zero
		end
	end

	always_ff @(posedge clock) begin
		romWord <= romNext; // registered read, one cycle after pc
	end

	always_ff @(negedge clock) begin
		romAtNeg <= romWord; // sample in the low phase
	end

	// pc moves on the falling edge, so a combinational path would show up here
	romOnEdgeOnly: assert property (@(posedge clock)
		!$isunknown(romAtNeg) |-> romWord == romAtNeg)
		else $error("romWord changed between clock edges");

endmodule

// File: progMem.sv
`timescale 1ns/100ps

module progMem #(
	parameter int PROG_WORDS = 1024
) (
	input logic clock,
	input logic rstN,
	input isaPkg::axiWrReqT axiReq,
	output isaPkg::axiWrRspT axiRsp,
	input logic [31:0] pc, // fetch word index
	output isaPkg::instrWordT ramWord
);

	localparam int IDX_W = $clog2(PROG_WORDS); // ram address width
	localparam logic [31:0] LOW = 32'(isaPkg::BIOS_WORDS); // first program word
	localparam logic [31:0] HIGH = 32'(isaPkg::BIOS_WORDS + PROG_WORDS); // one past last

	logic [3:0][7:0] mem [PROG_WORDS]; // byte lanes for strobes

	logic [31:0] wrWordIdx; // awaddr / 4
	logic [31:0] wrOff; // offset into ram
	logic [31:0] fetchOff;
	logic wrHit; // write lands in program window
	logic fetchHit;
	logic wrAccept; // address and data taken this cycle
	logic bValid;
	logic [1:0] bResp;

	function automatic logic inProg(input logic [31:0] idx);
		return idx >= LOW && idx < HIGH;
	endfunction

	assign wrWordIdx = {2'b00, axiReq.awaddr[31:2]};
	assign wrOff = wrWordIdx - LOW;
	assign fetchOff = pc - LOW;
	assign wrHit = inProg(wrWordIdx);
	assign fetchHit = inProg(pc);
	assign wrAccept = axiReq.awvalid && axiReq.wvalid && !bValid; // both channels together

	always_comb begin
		axiRsp.awready = wrAccept; // stalled only by pending response
		axiRsp.wready = wrAccept;
		axiRsp.bvalid = bValid;
		axiRsp.bresp = bResp;
	end

	always_ff @(posedge clock) begin
		if (wrAccept && wrHit) begin
			for (int b = 0; b < 4; b++) begin
				if (axiReq.wstrb[b]) begin
					mem[wrOff[IDX_W-1:0]][b] <= axiReq.wdata[8*b +: 8]; // lane b only
				end
			end
		end
	end

	// response channel
	always_ff @(posedge clock) begin
		if (!rstN) begin
			bValid <= 1'b0;
		end else if (bValid && axiReq.bready) begin
			bValid <= 1'b0; // handshake done
		end else if (wrAccept) begin
			bValid <= 1'b1; // response the cycle after accept
		end
	end

	always_ff @(posedge clock) begin
		if (wrAccept) begin
			bResp <= wrHit ? isaPkg::RESP_OKAY : isaPkg::RESP_SLVERR; // rom or past end
		end
	end

	always_ff @(posedge clock) begin
		if (fetchHit) begin
			ramWord <= mem[fetchOff[IDX_W-1:0]]; // decode ignores it otherwise
		end
	end

	bvalidHeld: assert property (@(posedge clock) disable iff (!rstN)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
		else $error("bvalid dropped before bready");

	noAcceptWhileResp: assert property (@(posedge clock) disable iff (!rstN)
		axiRsp.bvalid |-> !axiRsp.awready && !axiRsp.wready)
		else $error("awready or wready high with response pending");

endmodule

// File: instrDecode.sv
`timescale 1ns/100ps

module instrDecode #(
	parameter int PROG_WORDS = 1024
) (
	input logic clock,
	input logic rstN,
	input logic endBios, // one-cycle pulse
	input logic [31:0] pc,
	input isaPkg::instrWordT romWord,
	input isaPkg::instrWordT ramWord,
	output isaPkg::opcodeT opcode,
	output logic [4:0] rd,
	output logic [4:0] rs,
	output logic [4:0] rt,
	output logic [10:0] imm,
	output logic [25:0] target,
	output logic biosRunning,
	output logic addrFault
);

	localparam logic [31:0] LIMIT = 32'(isaPkg::BIOS_WORDS + PROG_WORDS); // first bad index

	logic wordValid; // a rom or ram word is in flight
	logic fromRam; // region of last pc
	isaPkg::instrWordT word; // selected fetch result

	// region tracking, aligned with the memories' read latency
	always_ff @(posedge clock) begin
		if (!rstN) begin
			wordValid <= 1'b0; // zero fields after reset
			fromRam <= 1'b0;
			addrFault <= 1'b0;
		end else begin
			wordValid <= pc < LIMIT;
			fromRam <= pc >= 32'(isaPkg::BIOS_WORDS);
			addrFault <= pc >= LIMIT; // past program memory
		end
	end

	always_comb begin
		if (!wordValid) begin
			word = '0; // fault or just out of reset
		end else if (fromRam) begin
			word = ramWord;
		end else begin
			word = romWord;
		end
	end

	assign opcode = word.r.opcode; // shared by both views
	assign rd = word.r.rd;
	assign rs = word.r.rs;
	assign rt = word.r.rt;
	assign imm = word.r.imm;
	assign target = word.j.target; // jump view of the same word

	always_ff @(posedge clock) begin
		if (!rstN) begin
			biosRunning <= 1'b1; // boot starts in bios
		end else if (endBios) begin
			biosRunning <= 1'b0; // sticky until reset
		end
	end

	biosOnlyFromReset: assert property (@(posedge clock)
		$rose(biosRunning) |-> $past(!rstN))
		else $error("biosRunning set again without reset");

endmodule

// File: instrMemory.sv
`timescale 1ns/100ps

module instrMemory #(
	parameter int PROG_WORDS = 1024 // program ram size in words
) (
	input logic clock,
	input logic rstN,
	input logic [31:0] pc, // fetch word index
	input logic endBios,
	input isaPkg::axiWrReqT axiReq, // host load port
	output isaPkg::axiWrRspT axiRsp,
	output isaPkg::opcodeT opcode,
	output logic [4:0] rd,
	output logic [4:0] rs,
	output logic [4:0] rt,
	output logic [10:0] imm,
	output logic [25:0] target,
	output logic biosRunning,
	output logic addrFault
);

	isaPkg::instrWordT romWord; // registered bios word
	isaPkg::instrWordT ramWord; // registered program word

	bootRom bootRom_i (
		.clock(clock),
		.pc(pc),
		.romWord(romWord)
	);

	progMem #(.PROG_WORDS(PROG_WORDS)) progMem_i (
		.clock(clock),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.pc(pc),
		.ramWord(ramWord)
	);

	instrDecode #(.PROG_WORDS(PROG_WORDS)) instrDecode_i (
		.clock(clock),
		.rstN(rstN),
		.endBios(endBios),
		.pc(pc),
		.romWord(romWord),
		.ramWord(ramWord),
		.opcode(opcode),
		.rd(rd),
		.rs(rs),
		.rt(rt),
		.imm(imm),
		.target(target),
		.biosRunning(biosRunning),
		.addrFault(addrFault)
	);

endmodule

// File: tbScoreboard.sv
`timescale 1ns/100ps

module tbScoreboard (
	input logic clock,
	input logic [5:0] opcode,
	input logic [4:0] rd, rs, rt,
	input logic [10:0] imm,
	input logic [25:0] target,
	input logic biosRunning, addrFault,
	input isaPkg::axiWrReqT axiReq,
	input isaPkg::axiWrRspT axiRsp,
	input logic fetchChk, // tb presents a fetch this cycle
	input logic [31:0] fetchPc,
	input logic [31:0] expWord,
	input logic expFault, expBios,
	input logic respChk, stallChk,
	input logic [1:0] expResp,
	output int errCount,
	output int testCount
);

	logic pendChk; // fetch in flight, checked one cycle later
	logic [31:0] pendPc, pendWord;
	logic pendFault, pendBios;
	logic respDone; // write response handshake at the last edge
	logic stallDone; // response held back at the last edge
	logic [31:0] respAddr;
	logic [1:0] respExp;
	isaPkg::axiWrRspT rspSeen; // response channel as seen at the last edge
	int rowErr; // errors seen in the current test

	initial begin
		errCount = 0;
		testCount = 0;
		pendChk = 1'b0;
	end

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("error t=%0t %s expected=%h actual=%h", $time, name, exp, act);
			errCount++;
			rowErr++;
		end
	endtask

	always @(posedge clock) begin
		pendChk <= fetchChk; // capture expectation with pc
		pendPc <= fetchPc;
		pendWord <= expWord;
		pendFault <= expFault;
		pendBios <= expBios;
		respDone <= respChk && axiRsp.bvalid && axiReq.bready; // handshake cycle
		stallDone <= stallChk; // response held back by bready
		respAddr <= axiReq.awaddr;
		respExp <= expResp;
		rspSeen <= axiRsp;
	end

	// fields are registered, so stable in the low phase
	always @(negedge clock) begin
		if (respDone) begin
			rowErr = 0;
			compare("bresp", 32'(respExp), 32'(rspSeen.bresp));
			testCount++;
			$display("test %0d write addr=%h resp=%0d: %s", testCount, respAddr,
				respExp, rowErr == 0 ? "ok" : "mismatch");
		end
		if (stallDone) begin
			compare("bvalid", 32'd1, 32'(rspSeen.bvalid));
			compare("awready", 32'd0, 32'(rspSeen.awready));
			compare("wready", 32'd0, 32'(rspSeen.wready));
		end
		if (pendChk) begin
			rowErr = 0;
			compare("opcode", 32'(pendWord[31:26]), 32'(opcode)); // both views share it
			compare("rd", 32'(pendWord[25:21]), 32'(rd));
			compare("rs", 32'(pendWord[20:16]), 32'(rs));
			compare("rt", 32'(pendWord[15:11]), 32'(rt));
			compare("imm", 32'(pendWord[10:0]), 32'(imm));
			compare("target", 32'(pendWord[25:0]), 32'(target)); // jump view
			compare("addrFault", 32'(pendFault), 32'(addrFault));
			compare("biosRunning", 32'(pendBios), 32'(biosRunning));
			compare("bvalid", 32'd0, 32'(axiRsp.bvalid)); // no write pending
			testCount++;
			$display("test %0d fetch pc=%0d: %s", testCount, pendPc,
				rowErr == 0 ? "ok" : "mismatch");
		end
	end

endmodule

// File: tbInstrMemory.sv
`timescale 1ns/100ps

module tbInstrMemory;

	localparam int PROG_WORDS = 1024;
	localparam int LIMIT = 37 + PROG_WORDS; // first index past program ram

	typedef struct packed {
		logic [1:0] kind; // 0 fetch, 1 write, 2 end bios
		logic [31:0] addr; // word index
		logic [31:0] data;
		logic [3:0] strb;
		logic [3:0] stall; // bready low cycles
		logic [31:0] expWord;
		logic [1:0] expResp;
		logic expFault;
		logic expBios;
	} rowT;

	logic clock = 1'b0;
	logic rstN, endBios, fetchChk, respChk, stallChk, timedOut;
	logic [31:0] pc;
	isaPkg::axiWrReqT axiReq;
	isaPkg::axiWrRspT axiRsp;
	isaPkg::opcodeT opcode;
	logic [4:0] rd, rs, rt;
	logic [10:0] imm;
	logic [25:0] target;
	logic biosRunning, addrFault;
	rowT row;
	rowT rows[$];
	logic [31:0] model [int]; // expected program ram
	logic biosModel;
	int errCount, testCount;

	always #10 clock = ~clock;

	instrMemory #(.PROG_WORDS(PROG_WORDS)) instrMemory_i (
		.clock(clock), .rstN(rstN), .pc(pc), .endBios(endBios),
		.axiReq(axiReq), .axiRsp(axiRsp), .opcode(opcode), .rd(rd), .rs(rs), .rt(rt),
		.imm(imm), .target(target), .biosRunning(biosRunning), .addrFault(addrFault)
	);

	tbScoreboard scoreboard_i (
		.clock(clock), .opcode(opcode), .rd(rd), .rs(rs), .rt(rt), .imm(imm),
		.target(target), .biosRunning(biosRunning), .addrFault(addrFault),
		.axiReq(axiReq), .axiRsp(axiRsp), .fetchChk(fetchChk), .fetchPc(pc),
		.expWord(row.expWord), .expFault(row.expFault), .expBios(biosModel),
		.respChk(respChk), .stallChk(stallChk), .expResp(row.expResp),
		.errCount(errCount), .testCount(testCount)
	);

	// boot image rebuilt from the instruction set description
	function automatic logic [31:0] refBios(input int n);
		case (n)
			0: return {isaPkg::opCproc, 26'd0};
			31: return {isaPkg::opMovi, 5'd30, 5'd0, 5'd0, 11'd1};
			32: return {isaPkg::opMovi, 5'd31, 5'd30, 5'd30, 11'd11};
			33: return {isaPkg::opSw, 5'd0, 5'd30, 5'd0, 11'd1};
			34: return {isaPkg::opAddi, 5'd30, 5'd30, 5'd30, 11'd1};
			35: return {isaPkg::opBeq, 5'd0, 5'd30, 5'd31, 11'd2};
			36: return {isaPkg::opJ, 26'd33};
			default: return {isaPkg::opMovi, 5'(n - 1), 21'd0}; // clear r(n-1)
		endcase
	endfunction

	task automatic addFetch(input int idx);
		rowT r;
		r = '0;
		r.addr = idx;
		if (idx < 37) r.expWord = refBios(idx);
		else if (idx < LIMIT) r.expWord = model[idx];
		else r.expFault = 1'b1; // zero word
		rows.push_back(r);
	endtask

	task automatic addWrite(input int idx, input logic [31:0] data, input logic [3:0] strb,
			input int stall);
		rowT r;
		logic [31:0] old;
		r = '0;
		r.kind = 2'd1;
		r.addr = idx;
		r.data = data;
		r.strb = strb;
		r.stall = 4'(stall);
		r.expResp = (idx >= 37 && idx < LIMIT) ? 2'd0 : 2'd2;
		if (r.expResp == 2'd0) begin
			old = model.exists(idx) ? model[idx] : 32'd0;
			for (int b = 0; b < 4; b++)
				if (strb[b]) old[8*b +: 8] = data[8*b +: 8]; // strobed lanes only
			model[idx] = old;
		end
		rows.push_back(r);
	endtask

	task automatic runWrite();
		logic acc;
		logic hs;
		axiReq.awaddr = row.addr << 2;
		axiReq.wdata = row.data;
		axiReq.wstrb = row.strb;
		axiReq.awvalid = 1'b1;
		axiReq.wvalid = 1'b1;
		axiReq.bready = row.stall == 0;
		respChk = 1'b1;
		acc = 1'b0;
		for (int n = 0; n < 20 && !acc; n++) begin
			@(posedge clock);
			acc = axiRsp.awready;
		end
		if (!acc) begin
			$display("timeout: write was not accepted within 20 cycles");
			timedOut = 1'b1;
		end
		@(negedge clock);
		if (row.stall != 0) begin
			stallChk = 1'b1; // valids stay high to probe back-pressure
			repeat (row.stall) @(negedge clock);
			stallChk = 1'b0;
			axiReq.bready = 1'b1;
		end
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		hs = 1'b0;
		for (int n = 0; n < 20 && !hs; n++) begin
			@(posedge clock);
			hs = axiRsp.bvalid && axiReq.bready;
		end
		if (!hs) begin
			$display("timeout: write response never completed");
			timedOut = 1'b1;
		end
		@(negedge clock);
		axiReq.bready = 1'b0;
		respChk = 1'b0;
	endtask

	initial begin
		void'($urandom(38));
		rstN = 1'b0;
		endBios = 1'b0;
		fetchChk = 1'b0;
		respChk = 1'b0;
		stallChk = 1'b0;
		timedOut = 1'b0;
		pc = '0;
		axiReq = '0;
		row = '0;
		biosModel = 1'b1;
		addFetch(0);
		for (int i = 0; i <= 36; i++) addFetch(i); // back to back
		begin
			int idx [4];
			for (int k = 0; k < 4; k++) begin
				idx[k] = 37 + ($urandom % PROG_WORDS);
				addWrite(idx[k], $urandom, 4'hf, 0);
			end
			for (int k = 0; k < 4; k++) addFetch(idx[k]);
			addWrite(idx[0], $urandom, 4'b0101, 0); // partial lanes
			addFetch(idx[0]);
		end
		addWrite(LIMIT - 32, 32'h600df00d, 4'hf, 0); // ram slot index 5 wraps onto
		addWrite(37, 32'h0badcafe, 4'hf, 0); // ram slot the first past-end index wraps onto
		addWrite(5, 32'hdeadbeef, 4'hf, 0); // rom is read only
		addFetch(5);
		addFetch(LIMIT - 32);
		addWrite(LIMIT, 32'h12345678, 4'hf, 0);
		addFetch(37);
		addWrite(40, 32'hcafe0001, 4'hf, 3);
		addFetch(40);
		addFetch(LIMIT);
		rows.push_back(rowT'({2'd2, 108'd0})); // end bios
		addFetch(0);
		addFetch(40);
		repeat (2) @(negedge clock);
		rstN = 1'b1;
		foreach (rows[i]) begin
			if (timedOut) break;
			row = rows[i];
			fetchChk = row.kind == 2'd0;
			if (row.kind == 2'd0) begin
				pc = row.addr;
				@(negedge clock);
			end else if (row.kind == 2'd1) begin
				runWrite();
			end else begin
				endBios = 1'b1;
				@(negedge clock);
				endBios = 1'b0;
				biosModel = 1'b0;
				$display("row %0d: endBios pulsed", i);
			end
		end
		fetchChk = 1'b0;
		repeat (3) @(negedge clock);
		$display("tests %0d, errors %0d, timeouts %0d", testCount, errCount, timedOut);
		if (errCount == 0 && !timedOut) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: filelist.f
isaPkg.sv
bootRom.sv
progMem.sv
instrDecode.sv
instrMemory.sv
tbScoreboard.sv
tbInstrMemory.sv

// File: run.sh
#!/bin/sh
# build and simulate, then look for the fail message in the log
verilator --binary --timing --assert --top-module tbInstrMemory -f filelist.f -o simv \
	> build.log 2>&1 && ./obj_dir/simv > sim.log 2>&1 || { echo "build or run failed"; exit 1; }
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
